// ==== rtl/mul_pkg.sv ====
// Operand and result formats for the streaming multiplier
// Unsigned operands only, and the product keeps its full width
package mul_pkg;

    // Operand width in bits
    localparam int op_w = 8;

    // Tag that rides along with each item
    localparam int tag_w = 4;

    // Full product width, never truncated
    localparam int prod_w = 2 * op_w;

    // One operand pair as it enters the design
    typedef struct packed {
        logic [op_w-1:0]  a;
        logic [op_w-1:0]  b;
        logic [tag_w-1:0] tag;
    } op_t;

    // One result as it leaves the design
    typedef struct packed {
        logic [prod_w-1:0] product;
        logic [tag_w-1:0]  tag;
    } res_t;

endpackage

// ==== rtl/stream_fifo.sv ====
// Valid/ready FIFO for any packed payload, DEPTH of 1 or more
// No same-cycle bypass, so an item waits at least one cycle inside
`timescale 1ns/10ps

module stream_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 2
) (
    input  logic clk,
    input  logic rst_n,

    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,

    output logic out_valid,
    output T     out_data,
    input  logic out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage has no reset, only count and pointers do
    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_wr;
    logic do_rd;

    // Wraps at DEPTH-1, so non power-of-two depths work too
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);

    assign do_wr = in_valid && in_ready;
    assign do_rd = out_valid && out_ready;

    // Head of the queue is always on the output
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            rd_ptr <= next_ptr(rd_ptr);
        end
    end

    // Simultaneous read and write leaves the count alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({do_wr, do_rd})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// ==== rtl/mul_stage_pipe.sv ====
// Unsigned multiplier pipe, STAGES register stages, one item per stage
// Whole pipe stalls together when the last stage is blocked
`timescale 1ns/10ps

module mul_stage_pipe #(
    parameter int STAGES = 3
) (
    input  logic          clk,
    input  logic          rst_n,

    input  logic          in_valid,
    output logic          in_ready,
    input  mul_pkg::op_t  in_data,

    output logic          out_valid,
    output mul_pkg::res_t out_data,
    input  logic          out_ready
);

    logic [STAGES-1:0] stage_valid;
    mul_pkg::res_t     stage_data [STAGES];

    mul_pkg::res_t     first_res;
    logic              advance;

    // Moves when the tail is empty or being taken
    assign advance  = !stage_valid[STAGES-1] || out_ready;
    assign in_ready = advance;

    // Full-width product, no rounding
    always_comb begin
        first_res.product = mul_pkg::prod_w'(in_data.a) * mul_pkg::prod_w'(in_data.b);
        first_res.tag     = in_data.tag;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid[0] <= in_valid;
            for (int i = 1; i < STAGES; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    // Payload follows the valid bits
    always_ff @(posedge clk) begin
        if (advance) begin
            if (in_valid) begin
                stage_data[0] <= first_res;
            end
            for (int i = 1; i < STAGES; i++) begin
                stage_data[i] <= stage_data[i-1];
            end
        end
    end

    assign out_valid = stage_valid[STAGES-1];
    assign out_data  = stage_data[STAGES-1];

endmodule

// ==== rtl/mul_pipe_top.sv ====
// Input FIFO, multiplier pipe and output FIFO in a row, order kept
// Unloaded latency is STAGES plus 2 cycles, capacity IN_DEPTH+STAGES+OUT_DEPTH
`timescale 1ns/10ps

module mul_pipe_top #(
    parameter int STAGES    = 3,
    parameter int IN_DEPTH  = 2,
    parameter int OUT_DEPTH = 4
) (
    input  logic          clk,
    input  logic          rst_n,

    input  logic          in_valid,
    output logic          in_ready,
    input  mul_pkg::op_t  in_data,

    output logic          out_valid,
    output mul_pkg::res_t out_data,
    input  logic          out_ready
);

    // Input FIFO to pipe
    logic          buf_valid;
    logic          buf_ready;
    mul_pkg::op_t  buf_data;

    // Pipe to output FIFO
    logic          mul_valid;
    logic          mul_ready;
    mul_pkg::res_t mul_data;

    stream_fifo #(
        .T     (mul_pkg::op_t),
        .DEPTH (IN_DEPTH)
    ) in_buf_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (buf_valid),
        .out_data  (buf_data),
        .out_ready (buf_ready)
    );

    mul_stage_pipe #(
        .STAGES (STAGES)
    ) pipe_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (buf_valid),
        .in_ready  (buf_ready),
        .in_data   (buf_data),
        .out_valid (mul_valid),
        .out_data  (mul_data),
        .out_ready (mul_ready)
    );

    stream_fifo #(
        .T     (mul_pkg::res_t),
        .DEPTH (OUT_DEPTH)
    ) out_buf_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mul_valid),
        .in_ready  (mul_ready),
        .in_data   (mul_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

// ==== bench/mul_pipe_assert.sv ====
// Output handshake checks, bound into every mul_pipe_top
// fail_count lets the testbench see a failed property
`timescale 1ns/10ps

module mul_pipe_assert (
    input logic          clk,
    input logic          rst_n,
    input logic          in_ready,
    input logic          out_valid,
    input logic          out_ready,
    input mul_pkg::res_t out_data
);

    int fail_count = 0;

    // A waiting result must neither change nor vanish
    property out_held;
        @(posedge clk) disable iff (!rst_n)
            out_valid && !out_ready |=> out_valid && $stable(out_data);
    endproperty

    property out_valid_known;
        @(posedge clk) disable iff (!rst_n) !$isunknown(out_valid);
    endproperty

    // Empty input FIFO takes data right after reset
    property ready_after_reset;
        @(posedge clk) $rose(rst_n) |-> in_ready;
    endproperty

    out_held_a: assert property (out_held) else begin
        fail_count++;
        $error("out_valid or out_data changed while waiting for out_ready");
    end

    out_valid_known_a: assert property (out_valid_known) else begin
        fail_count++;
        $error("out_valid is unknown after reset");
    end

    ready_after_reset_a: assert property (ready_after_reset) else begin
        fail_count++;
        $error("in_ready is low in the first cycle after reset");
    end

endmodule

bind mul_pipe_top mul_pipe_assert assert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

// ==== bench/mul_pipe_tb.sv ====
// Table-driven bench for mul_pipe_top at its default parameters
// Expected products are worked out by hand in the table
`timescale 1ns/10ps

module mul_pipe_tb;

    localparam int STAGES    = 3;
    localparam int IN_DEPTH  = 2;
    localparam int OUT_DEPTH = 4;
    localparam int CAPACITY  = IN_DEPTH + STAGES + OUT_DEPTH;
    localparam int N_VEC     = 20;
    // Latency item, two table passes, capacity fill and the item left waiting
    localparam int TOTAL_ITEMS = 1 + 2 * N_VEC + CAPACITY + 1;
    localparam int MAX_CYCLES  = TOTAL_ITEMS * (STAGES + 8) + 100;

    typedef struct packed {
        logic [mul_pkg::op_w-1:0]   a;
        logic [mul_pkg::op_w-1:0]   b;
        logic [mul_pkg::prod_w-1:0] product;
    } vec_t;

    // a, b, product
    vec_t vecs [N_VEC] = '{
        '{8'd0,   8'd37,  16'd0},     '{8'd37,  8'd0,   16'd0},
        '{8'd255, 8'd255, 16'd65025}, '{8'd1,   8'd200, 16'd200},
        '{8'd200, 8'd1,   16'd200},   '{8'd255, 8'd1,   16'd255},
        '{8'd1,   8'd1,   16'd1},     '{8'd12,  8'd34,  16'd408},
        '{8'd100, 8'd100, 16'd10000}, '{8'd128, 8'd2,   16'd256},
        '{8'd2,   8'd128, 16'd256},   '{8'd255, 8'd254, 16'd64770},
        '{8'd17,  8'd15,  16'd255},   '{8'd99,  8'd101, 16'd9999},
        '{8'd16,  8'd16,  16'd256},   '{8'd250, 8'd3,   16'd750},
        '{8'd7,   8'd9,   16'd63},    '{8'd128, 8'd128, 16'd16384},
        '{8'd64,  8'd200, 16'd12800}, '{8'd3,   8'd85,  16'd255}
    };

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    logic          in_ready;
    mul_pkg::op_t  in_data;
    logic          out_valid;
    mul_pkg::res_t out_data;
    logic          out_ready;

    logic [31:0]                 lcg_state;
    logic                        rand_ready;
    logic [mul_pkg::prod_w-1:0]  cur_product;
    logic [mul_pkg::tag_w-1:0]   next_tag;
    mul_pkg::res_t               exp_q [$];
    mul_pkg::res_t               got_in;
    mul_pkg::res_t               want;
    int cycle = 0;
    int in_cyc;
    int out_cyc;
    int n_sent = 0;
    int n_recv = 0;
    int accepted;

    mul_pipe_top #(
        .STAGES    (STAGES),
        .IN_DEPTH  (IN_DEPTH),
        .OUT_DEPTH (OUT_DEPTH)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, items stopped moving through the DUT", cycle);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Next drive point, with a fresh out_ready level in random mode
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        if (rand_ready) begin
            r = lcg_next();
            out_ready = r[31];
        end
    endtask

    task automatic load_item(input int idx);
        in_data.a   = vecs[idx % N_VEC].a;
        in_data.b   = vecs[idx % N_VEC].b;
        in_data.tag = next_tag;
        cur_product = vecs[idx % N_VEC].product;
    endtask

    // Valid and data stay put until the transfer edge has passed
    task automatic send_item(input int idx);
        logic taken;
        load_item(idx);
        in_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            taken = in_ready;
            next_cycle();
        end
        in_valid = 1'b0;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    // Mid-cycle sampling, each transfer happens at the following edge
    always @(negedge clk) begin
        if (rst_n) begin
            assert (dut_i.assert_i.fail_count == 0) else
                stop_with_error("A bound handshake assertion failed");
            if (in_valid && in_ready) begin
                got_in.product = cur_product;
                got_in.tag     = in_data.tag;
                exp_q.push_back(got_in);
                in_cyc = cycle;
                n_sent++;
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0) else
                    stop_with_error($sformatf("Output with tag %0d came with no input left",
                                              out_data.tag));
                want = exp_q.pop_front();
                assert (out_data == want) else
                    stop_with_error($sformatf(
                        "[ERROR] %0t: got tag %0d product %0d, expected tag %0d product %0d",
                        $time, out_data.tag, out_data.product, want.tag, want.product));
                out_cyc = cycle;
                n_recv++;
            end
        end
    end

    initial begin
        logic [31:0] r;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        out_ready   = 1'b0;
        rand_ready  = 1'b0;
        lcg_state   = 32'h2430_8c4e;
        next_tag    = '0;
        cur_product = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (out_valid == 1'b0) else stop_with_error("out_valid is high after reset");
        assert (in_ready == 1'b1) else stop_with_error("in_ready is low after reset");

        // One item through the empty design
        out_ready = 1'b1;
        send_item(0);
        drain();
        assert (out_cyc - in_cyc == 2 + STAGES) else
            stop_with_error($sformatf("[ERROR] %0t: latency %0d cycles, expected %0d",
                                      $time, out_cyc - in_cyc, 2 + STAGES));

        // Back to back with the sink always ready
        for (int i = 0; i < N_VEC; i++) begin
            send_item(i);
        end
        drain();

        // Random input gaps and random out_ready
        rand_ready = 1'b1;
        for (int i = 0; i < N_VEC; i++) begin
            r = lcg_next();
            repeat (r[17:16]) next_cycle();
            send_item(i);
        end
        drain();
        rand_ready = 1'b0;

        // Fill with the sink stalled, then let it drain
        out_ready = 1'b0;
        accepted  = 0;
        load_item(0);
        in_valid = 1'b1;
        while (in_ready) begin
            next_cycle();
            accepted++;
            next_tag = next_tag + 1'b1;
            load_item(accepted);
        end
        assert (accepted == CAPACITY) else
            stop_with_error($sformatf("[ERROR] %0t: %0d items taken while stalled, expected %0d",
                                      $time, accepted, CAPACITY));
        repeat (4) begin
            next_cycle();
            assert (!in_ready) else stop_with_error("in_ready rose while out_ready was low");
        end
        out_ready = 1'b1;
        send_item(accepted);
        drain();

        if (exp_q.size() == 0 && n_sent == TOTAL_ITEMS && n_recv == TOTAL_ITEMS) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "%0d items sent and %0d received, %0d expected", n_sent, n_recv,
                   TOTAL_ITEMS);
        end
    end

endmodule

// ==== mul_pipe.f ====
rtl/mul_pkg.sv
rtl/stream_fifo.sv
rtl/mul_stage_pipe.sv
rtl/mul_pipe_top.sv
bench/mul_pipe_assert.sv
bench/mul_pipe_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = mul_pipe_tb
FILELIST  = mul_pipe.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
